// File: build.f
+incdir+source
source/nand_pkg.sv
source/nand_latch_unit.sv
source/nand_io_unit.sv
source/nand_pin_driver.sv
source/nand_controller.sv
source/nand_master.sv
verification/nand_flash_model.sv
verification/tb_nand_master.sv

// File: Bender.yml
package:
  name: nand_master

export_include_dirs:
  - source

sources:
  - include_dirs:
      - source
    files:
      - source/nand_pkg.sv
      - source/nand_latch_unit.sv
      - source/nand_io_unit.sv
      - source/nand_pin_driver.sv
      - source/nand_controller.sv
      - source/nand_master.sv
  - target: simulation
    include_dirs:
      - source
    files:
      - verification/nand_flash_model.sv
      - verification/tb_nand_master.sv

// File: verification/tb_nand_master.sv
`timescale 1ns/1ps
`include "nand_consts.svh"

module tb_nand_master;

	localparam int clk_half = 50;
	// Full sequence runs a few hundred cycles, NAND RESET being the longest step
	localparam int timeout_cycles = 4000;
	localparam logic [31:0] seed = 32'hf16846fc;
	localparam logic [8*`NAND_ID_LEN-1:0] id_code = 40'h2cda909506;
	localparam logic [7:0] chip_status = 8'he0;
	localparam int reset_hold = 30;

	logic clk;
	logic nreset;
	logic activate;
	nand_pkg::host_req_t req;
	logic busy;
	logic [`HOST_DATA_W-1:0] data_out;
	nand_pkg::nand_ctrl_t nand_ctrl;
	wire [`NAND_DATA_W-1:0] nand_data;
	wire nand_rnb;

	// Model side view
	logic model_drive;
	logic [7:0] last_cmd;
	logic [7:0] last_addr;
	logic [7:0] last_data;
	logic [7:0] read_byte;
	int cmd_count;
	int addr_count;
	int data_count;

	int checks = 0;
	int errors = 0;
	int pin_errors = 0;
	int cycle_count = 0;
	int we_high = 0;
	logic dut_drives;

	nand_master DUT (
		.clk(clk), .nreset(nreset), .activate(activate), .req(req),
		.busy(busy), .data_out(data_out),
		.nand_ctrl(nand_ctrl), .nand_data(nand_data), .nand_rnb(nand_rnb)
	);

	nand_flash_model #(
		.id_code(id_code), .status_byte(chip_status), .reset_hold(reset_hold)
	) u_flash (
		.clk(clk), .nand_ctrl(nand_ctrl), .nand_data(nand_data), .nand_rnb(nand_rnb),
		.drive(model_drive), .last_cmd(last_cmd), .last_addr(last_addr),
		.last_data(last_data), .read_byte(read_byte),
		.cmd_count(cmd_count), .addr_count(addr_count), .data_count(data_count)
	);

	initial begin
		clk = 1'b0;
		forever #clk_half clk = ~clk;
	end

	// --------------------
	// Pin rules
	// --------------------

	// Bus carries a value the model did not put there
	// A clash with the model shows up as unknown bits
	assign dut_drives = model_drive ? $isunknown(nand_data)
		: (nand_data !== {`NAND_DATA_W{1'bz}});

	// Cycles since WE# last went high
	always @(posedge clk) begin
		if (!nreset || !nand_ctrl.we_n) begin
			we_high <= 0;
		end else if (we_high < 15) begin
			we_high <= we_high + 1;
		end
	end

	assert property (@(posedge clk) disable iff (!nreset) !(nand_ctrl.cle && nand_ctrl.ale))
		else begin
			pin_errors++;
			$display("error at %0t: CLE and ALE high together", $time);
		end

	assert property (@(posedge clk) disable iff (!nreset)
		dut_drives |-> (!nand_ctrl.we_n || we_high < `T_WH))
		else begin
			pin_errors++;
			$display("error at %0t: data bus driven outside a WE# cycle", $time);
		end

	assert property (@(posedge clk) disable iff (!nreset) nand_ctrl.we_n || nand_ctrl.re_n)
		else begin
			pin_errors++;
			$display("error at %0t: WE# and RE# low together", $time);
		end

	// Run limit
	always @(posedge clk) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= timeout_cycles) begin
			$display("timeout after %0d cycles, host sequence never finished", cycle_count);
			$display("checks %0d, value errors %0d, pin rule errors %0d",
				checks, errors, pin_errors);
			$display("Simulation failed");
			$finish;
		end
	end

	// --------------------
	// Host side tasks
	// --------------------

	// One request, back once busy has fallen
	task automatic run_cmd(input nand_pkg::host_cmd_e cmd, input logic [7:0] arg,
		output logic [7:0] result, output int busy_len);
		busy_len = 0;
		@(negedge clk);
		activate = 1'b1;
		req.cmd = cmd;
		req.data = arg;
		@(negedge clk);
		activate = 1'b0;
		while (busy) begin
			busy_len++;
			@(negedge clk);
		end
		result = data_out;
	endtask

	task automatic check_value(input string name, input logic [7:0] got, input logic [7:0] exp);
		checks++;
		assert (got === exp) else begin
			errors++;
			$display("mismatch at %0t: %s is %h, expected %h", $time, name, got, exp);
		end
	endtask

	task automatic check_cond(input bit ok, input string what);
		checks++;
		assert (ok) else begin
			errors++;
			$display("error at %0t: %s", $time, what);
		end
	endtask

	// Commands that finish in one busy cycle
	task automatic single_cmd(input nand_pkg::host_cmd_e cmd);
		logic [7:0] result;
		int busy_len;
		run_cmd(cmd, 8'h00, result, busy_len);
		check_cond(busy_len == 1, "single-cycle command not busy for exactly one cycle");
	endtask

	task automatic expect_status(input logic [7:0] exp);
		logic [7:0] result;
		int busy_len;
		run_cmd(nand_pkg::GET_STATUS, 8'h00, result, busy_len);
		check_value("data_out (status)", result, exp);
		check_cond(busy_len == 1, "GET_STATUS not busy for exactly one cycle");
	endtask

	// Pin register trails the controller by a cycle
	task automatic expect_pins(input logic ce_n, input logic wp_n);
		@(negedge clk);
		check_value("nand_ctrl.ce_n", nand_ctrl.ce_n, ce_n);
		check_value("nand_ctrl.wp_n", nand_ctrl.wp_n, wp_n);
	endtask

	function automatic logic [7:0] status_value(input bit oor, input bit wp, input bit ce);
		return {3'b000, oor, wp, ce, 2'b00};
	endfunction

	function automatic logic [7:0] id_byte(input int i);
		return id_code[8*(`NAND_ID_LEN-1-i) +: 8];
	endfunction

	// Random byte that the model will not take as one of its own opcodes
	function automatic logic [7:0] pick_byte();
		logic [7:0] b;
		b = 8'($urandom);
		if (b inside {`OP_RESET, `OP_READ_ID, `OP_READ_STATUS}) begin
			b = b ^ 8'h01;
		end
		return b;
	endfunction

	// --------------------
	// Test sequence
	// --------------------
	initial begin
		logic [7:0] result;
		int busy_len;
		int count_before;
		logic [7:0] cmd_byte;
		logic [7:0] addr_byte;
		logic [7:0] wr_byte;
		nreset = 1'b0;
		activate = 1'b0;
		req = '0;
		void'($urandom(seed));
		repeat (4) @(posedge clk);
		@(negedge clk);
		nreset = 1'b1;

		// Reset values
		check_value("nand_ctrl.ce_n", nand_ctrl.ce_n, 1'b1);
		check_value("nand_ctrl.wp_n", nand_ctrl.wp_n, 1'b0);
		check_value("busy", busy, 1'b0);
		expect_status(status_value(0, 1, 0));

		// Chip select and write protect
		single_cmd(nand_pkg::CHIP_ENABLE);
		single_cmd(nand_pkg::WRITE_ENABLE);
		expect_pins(1'b0, 1'b1);
		expect_status(status_value(0, 0, 1));
		single_cmd(nand_pkg::CHIP_DISABLE);
		single_cmd(nand_pkg::WRITE_PROTECT);
		expect_pins(1'b1, 1'b0);
		expect_status(status_value(0, 1, 0));

		// READ ID and byte-wise readout
		single_cmd(nand_pkg::CHIP_ENABLE);
		single_cmd(nand_pkg::WRITE_ENABLE);
		count_before = cmd_count;
		run_cmd(nand_pkg::READ_ID, 8'h00, result, busy_len);
		check_cond(cmd_count == count_before + 1, "READ ID command never reached the chip");
		check_value("model command", last_cmd, `OP_READ_ID);
		check_value("model address", last_addr, 8'h00);
		single_cmd(nand_pkg::RESET_INDEX);
		for (int i = 0; i < `NAND_ID_LEN; i++) begin
			run_cmd(nand_pkg::GET_ID_BYTE, 8'h00, result, busy_len);
			check_value("data_out (ID byte)", result, id_byte(i));
		end
		run_cmd(nand_pkg::GET_ID_BYTE, 8'h00, result, busy_len);
		check_value("data_out (ID past end)", result, 8'h00);
		expect_status(status_value(1, 0, 1));
		run_cmd(nand_pkg::GET_ID_BYTE, 8'h00, result, busy_len);
		check_value("data_out (ID byte)", result, id_byte(0));
		expect_status(status_value(0, 0, 1));

		// Bypass cycles with random bytes
		cmd_byte = pick_byte();
		addr_byte = pick_byte();
		wr_byte = pick_byte();
		run_cmd(nand_pkg::BYPASS_COMMAND, cmd_byte, result, busy_len);
		check_value("model command", last_cmd, cmd_byte);
		count_before = addr_count;
		run_cmd(nand_pkg::BYPASS_ADDRESS, addr_byte, result, busy_len);
		check_cond(addr_count == count_before + 1, "bypass address never reached the chip");
		check_value("model address", last_addr, addr_byte);
		count_before = data_count;
		run_cmd(nand_pkg::BYPASS_DATA_WR, wr_byte, result, busy_len);
		check_cond(data_count == count_before + 1, "bypass data byte never reached the chip");
		check_value("model data", last_data, wr_byte);
		run_cmd(nand_pkg::BYPASS_DATA_RD, 8'h00, result, busy_len);
		check_value("data_out (bypass read)", result, read_byte);

		// READ STATUS and NAND RESET
		run_cmd(nand_pkg::READ_STATUS, 8'h00, result, busy_len);
		check_value("model command", last_cmd, `OP_READ_STATUS);
		check_value("data_out (chip status)", result, chip_status);
		run_cmd(nand_pkg::NAND_RESET, 8'h00, result, busy_len);
		check_value("model command", last_cmd, `OP_RESET);
		check_cond(busy_len >= reset_hold, "busy fell while the chip still held R/B# low");

		$display("checks %0d, value errors %0d, pin rule errors %0d",
			checks, errors, pin_errors);
		if (errors == 0 && pin_errors == 0) begin
			$display("Simulation completed successfully");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule

// File: verification/nand_flash_model.sv
`timescale 1ns/1ps
`include "nand_consts.svh"

module nand_flash_model #(
	// ID bytes, first byte in the top bits
	parameter logic [8*`NAND_ID_LEN-1:0] id_code = 40'h2cda909506,
	parameter logic [`NAND_DATA_W-1:0] status_byte = 8'he0,
	// Busy time of a RESET, in clock cycles
	parameter int reset_hold = 30
) (
	input logic clk,
	input nand_pkg::nand_ctrl_t nand_ctrl,
	inout wire [`NAND_DATA_W-1:0] nand_data,
	output logic nand_rnb,
	output logic drive,
	output logic [`NAND_DATA_W-1:0] last_cmd,
	output logic [`NAND_DATA_W-1:0] last_addr,
	output logic [`NAND_DATA_W-1:0] last_data,
	output logic [`NAND_DATA_W-1:0] read_byte,
	output int cmd_count,
	output int addr_count,
	output int data_count
);

	logic [`NAND_DATA_W-1:0] dout;
	int id_pos;
	int served_cmd;
	event reset_start;

	assign nand_data = drive ? dout : 'z;

	// --------------------
	// Write side
	// --------------------

	// Bytes latched on the rising WE# edge, only while selected
	initial begin
		last_cmd = '0;
		last_addr = '0;
		last_data = '0;
		cmd_count = 0;
		addr_count = 0;
		data_count = 0;
		forever begin
			@(posedge nand_ctrl.we_n);
			if (nand_ctrl.ce_n === 1'b0) begin
				if (nand_ctrl.cle) begin
					last_cmd = nand_data;
					cmd_count++;
					if (nand_data == `OP_RESET) begin
						-> reset_start;
					end
				end else if (nand_ctrl.ale) begin
					last_addr = nand_data;
					addr_count++;
				end else begin
					last_data = nand_data;
					data_count++;
				end
			end
		end
	end

	// R/B# low for a fixed time after RESET
	initial begin
		nand_rnb = 1'b1;
		forever begin
			@(reset_start);
			nand_rnb = 1'b0;
			repeat (reset_hold) @(posedge clk);
			nand_rnb = 1'b1;
		end
	end

	// --------------------
	// Read side
	// --------------------

	// Byte comes out on the falling RE# edge, chosen by the last command
	initial begin
		drive = 1'b0;
		dout = '0;
		read_byte = '0;
		id_pos = 0;
		served_cmd = 0;
		forever begin
			@(nand_ctrl.re_n);
			if (nand_ctrl.re_n === 1'b1) begin
				// Short output hold after RE# rises
				#1 drive = 1'b0;
			end else if (nand_ctrl.re_n === 1'b0 && nand_ctrl.ce_n === 1'b0) begin
				// A new command restarts the ID sequence
				if (served_cmd != cmd_count) begin
					id_pos = 0;
					served_cmd = cmd_count;
				end
				if (last_cmd == `OP_READ_ID) begin
					dout = id_code[8*(`NAND_ID_LEN-1-id_pos) +: 8];
					id_pos = (id_pos + 1) % `NAND_ID_LEN;
				end else if (last_cmd == `OP_READ_STATUS) begin
					dout = status_byte;
				end else begin
					read_byte = 8'($urandom);
					dout = read_byte;
				end
				drive = 1'b1;
			end
		end
	end

endmodule

// File: source/nand_master.sv
`timescale 1ns/1ps
`include "nand_consts.svh"

module nand_master (
	input logic clk,
	input logic nreset,
	input logic activate,
	input nand_pkg::host_req_t req,
	output logic busy,
	output logic [`HOST_DATA_W-1:0] data_out,
	output nand_pkg::nand_ctrl_t nand_ctrl,
	inout wire [`NAND_DATA_W-1:0] nand_data,
	input logic nand_rnb
);

	// Unit handshakes
	logic cmd_act;
	logic addr_act;
	logic wr_act;
	logic rd_act;
	logic cmd_busy;
	logic addr_busy;
	logic wr_busy;
	logic rd_busy;
	logic [`NAND_DATA_W-1:0] cmd_data;
	logic [`NAND_DATA_W-1:0] addr_data;
	logic [`NAND_DATA_W-1:0] wr_data;
	logic [`NAND_DATA_W-1:0] rd_data;

	// Unit pin requests
	nand_pkg::unit_pins_t cmd_pins;
	nand_pkg::unit_pins_t addr_pins;
	nand_pkg::unit_pins_t wr_pins;
	nand_pkg::unit_pins_t rd_pins;

	// Pin side
	logic ce_n;
	logic wp_n;
	logic rnb;
	logic [`NAND_DATA_W-1:0] bus_in;

	nand_controller u_controller (
		.clk(clk), .nreset(nreset), .activate(activate), .req(req),
		.busy(busy), .data_out(data_out),
		.cmd_act(cmd_act), .addr_act(addr_act), .wr_act(wr_act), .rd_act(rd_act),
		.cmd_data(cmd_data), .addr_data(addr_data), .wr_data(wr_data),
		.cmd_busy(cmd_busy), .addr_busy(addr_busy), .wr_busy(wr_busy), .rd_busy(rd_busy),
		.rnb(rnb), .rd_data(rd_data), .ce_n(ce_n), .wp_n(wp_n)
	);

	// CLE and ALE cycles
	nand_latch_unit #(.is_address(1'b0)) u_cmd_latch (
		.clk(clk), .nreset(nreset), .activate(cmd_act), .data(cmd_data),
		.busy(cmd_busy), .pins(cmd_pins)
	);

	nand_latch_unit #(.is_address(1'b1)) u_addr_latch (
		.clk(clk), .nreset(nreset), .activate(addr_act), .data(addr_data),
		.busy(addr_busy), .pins(addr_pins)
	);

	// Data write and read cycles
	nand_io_unit #(.is_read(1'b0)) u_io_wr (
		.clk(clk), .nreset(nreset), .activate(wr_act), .data(wr_data),
		.busy(wr_busy), .pins(wr_pins), .bus_in(bus_in), .rd_data()
	);

	nand_io_unit #(.is_read(1'b1)) u_io_rd (
		.clk(clk), .nreset(nreset), .activate(rd_act), .data('0),
		.busy(rd_busy), .pins(rd_pins), .bus_in(bus_in), .rd_data(rd_data)
	);

	nand_pin_driver u_pin_driver (
		.clk(clk), .nreset(nreset),
		.cmd_pins(cmd_pins), .addr_pins(addr_pins), .wr_pins(wr_pins), .rd_pins(rd_pins),
		.ce_n(ce_n), .wp_n(wp_n), .nand_ctrl(nand_ctrl), .nand_data(nand_data),
		.nand_rnb(nand_rnb), .rnb(rnb), .bus_in(bus_in)
	);

endmodule

// File: source/nand_controller.sv
`timescale 1ns/1ps
`include "nand_consts.svh"

module nand_controller (
	input logic clk,
	input logic nreset,
	input logic activate,
	input nand_pkg::host_req_t req,
	output logic busy,
	output logic [`HOST_DATA_W-1:0] data_out,
	output logic cmd_act,
	output logic addr_act,
	output logic wr_act,
	output logic rd_act,
	output logic [`NAND_DATA_W-1:0] cmd_data,
	output logic [`NAND_DATA_W-1:0] addr_data,
	output logic [`NAND_DATA_W-1:0] wr_data,
	input logic cmd_busy,
	input logic addr_busy,
	input logic wr_busy,
	input logic rd_busy,
	input logic rnb,
	input logic [`NAND_DATA_W-1:0] rd_data,
	output logic ce_n,
	output logic wp_n
);

	localparam int idx_w = $clog2(`NAND_ID_LEN + 1);
	localparam logic [idx_w-1:0] id_len = idx_w'(`NAND_ID_LEN);
	localparam logic [idx_w-1:0] id_last = idx_w'(`NAND_ID_LEN - 1);
	localparam logic [`DELAY_W-1:0] wb_cycles = `T_WB;
	localparam logic [`DELAY_W-1:0] whr_cycles = `T_WHR;

	nand_pkg::ctrl_state_e state;
	nand_pkg::ctrl_state_e ret_state;
	nand_pkg::step_e step;
	nand_pkg::host_req_t req_q;
	nand_pkg::status_t status;
	logic [`DELAY_W-1:0] delay;
	logic [idx_w-1:0] index;
	logic [`NAND_DATA_W-1:0] id_buf [`NAND_ID_LEN];
	logic units_idle;

	assign busy = (state != nand_pkg::IDLE);
	assign units_idle = !(cmd_busy | addr_busy | wr_busy | rd_busy);

	// --------------------
	// Unit activation
	// --------------------
	always_comb begin
		cmd_act = 1'b0;
		addr_act = 1'b0;
		wr_act = 1'b0;
		rd_act = 1'b0;
		if (state == nand_pkg::EXEC) begin
			case (step)
				nand_pkg::BEGIN: begin
					cmd_act = req_q.cmd inside {nand_pkg::NAND_RESET, nand_pkg::READ_STATUS,
						nand_pkg::READ_ID, nand_pkg::BYPASS_COMMAND};
					addr_act = (req_q.cmd == nand_pkg::BYPASS_ADDRESS);
				end
				// READ ID address cycle
				nand_pkg::SUBMIT_COMMAND: addr_act = (req_q.cmd == nand_pkg::READ_ID);
				nand_pkg::WRITE_DATA0: wr_act = 1'b1;
				nand_pkg::READ_DATA0: rd_act = 1'b1;
				default: ;
			endcase
		end
	end

	// Opcode bytes, host byte for the bypass operations
	always_comb begin
		case (req_q.cmd)
			nand_pkg::NAND_RESET: cmd_data = `OP_RESET;
			nand_pkg::READ_STATUS: cmd_data = `OP_READ_STATUS;
			nand_pkg::READ_ID: cmd_data = `OP_READ_ID;
			default: cmd_data = req_q.data;
		endcase
		addr_data = (req_q.cmd == nand_pkg::READ_ID) ? '0 : req_q.data;
	end

	assign wr_data = req_q.data;

	// --------------------
	// Main FSM
	// --------------------
	always_ff @(posedge clk) begin
		if (!nreset) begin
			state <= nand_pkg::IDLE;
			ret_state <= nand_pkg::IDLE;
			step <= nand_pkg::BEGIN;
			delay <= '0;
			index <= '0;
			status <= nand_pkg::status_t'(`STATUS_RESET);
			ce_n <= 1'b1;
			wp_n <= 1'b0;
		end else begin
			case (state)
				nand_pkg::IDLE: begin
					if (activate) begin
						state <= nand_pkg::EXEC;
						step <= nand_pkg::BEGIN;
					end
				end
				// Loaded delay first, then units idle and chip ready
				nand_pkg::WAIT: begin
					if (delay != '0) begin
						delay <= delay - 1'b1;
					end else if (units_idle && rnb) begin
						state <= ret_state;
					end
				end
				nand_pkg::DELAY: begin
					if (delay != '0) begin
						delay <= delay - 1'b1;
					end else begin
						state <= ret_state;
					end
				end
				default: begin
					case (req_q.cmd)
						nand_pkg::GET_STATUS: state <= nand_pkg::IDLE;
						nand_pkg::CHIP_ENABLE: begin
							ce_n <= 1'b0;
							status.chip_enabled <= 1'b1;
							state <= nand_pkg::IDLE;
						end
						nand_pkg::CHIP_DISABLE: begin
							ce_n <= 1'b1;
							status.chip_enabled <= 1'b0;
							state <= nand_pkg::IDLE;
						end
						nand_pkg::WRITE_PROTECT: begin
							wp_n <= 1'b0;
							status.write_protected <= 1'b1;
							state <= nand_pkg::IDLE;
						end
						nand_pkg::WRITE_ENABLE: begin
							wp_n <= 1'b1;
							status.write_protected <= 1'b0;
							state <= nand_pkg::IDLE;
						end
						nand_pkg::RESET_INDEX: begin
							index <= '0;
							state <= nand_pkg::IDLE;
						end
						// Past the last ID byte the index wraps and flags the miss
						nand_pkg::GET_ID_BYTE: begin
							if (index < id_len) begin
								index <= index + 1'b1;
								status.out_of_range <= 1'b0;
							end else begin
								index <= '0;
								status.out_of_range <= 1'b1;
							end
							state <= nand_pkg::IDLE;
						end
						default: begin
							case (step)
								nand_pkg::BEGIN: begin
									ret_state <= nand_pkg::EXEC;
									delay <= '0;
									if (req_q.cmd == nand_pkg::BYPASS_DATA_WR) begin
										step <= nand_pkg::WRITE_DATA0;
									end else if (req_q.cmd == nand_pkg::BYPASS_DATA_RD) begin
										step <= nand_pkg::READ_DATA0;
									end else begin
										// Command or address cycle started in this cycle
										state <= nand_pkg::WAIT;
										step <= (req_q.cmd == nand_pkg::BYPASS_ADDRESS) ?
											nand_pkg::SUBMIT_ADDRESS : nand_pkg::SUBMIT_COMMAND;
									end
								end
								nand_pkg::SUBMIT_COMMAND: begin
									if (req_q.cmd == nand_pkg::READ_ID) begin
										state <= nand_pkg::WAIT;
										step <= nand_pkg::SUBMIT_ADDRESS;
									end else if (req_q.cmd == nand_pkg::READ_STATUS) begin
										delay <= whr_cycles;
										state <= nand_pkg::DELAY;
										step <= nand_pkg::READ_DATA0;
									end else begin
										// Give R/B# time to fall before it is checked
										delay <= wb_cycles;
										state <= nand_pkg::WAIT;
										step <= nand_pkg::FINISH;
									end
								end
								nand_pkg::SUBMIT_ADDRESS: begin
									if (req_q.cmd == nand_pkg::READ_ID) begin
										delay <= whr_cycles;
										state <= nand_pkg::DELAY;
										step <= nand_pkg::READ_DATA0;
										index <= '0;
									end else begin
										delay <= wb_cycles;
										state <= nand_pkg::WAIT;
										step <= nand_pkg::FINISH;
									end
								end
								// Single data byte, done once the writer is idle
								nand_pkg::WRITE_DATA0: begin
									ret_state <= nand_pkg::IDLE;
									state <= nand_pkg::WAIT;
								end
								nand_pkg::READ_DATA0: begin
									state <= nand_pkg::WAIT;
									step <= nand_pkg::READ_DATA1;
								end
								nand_pkg::READ_DATA1: begin
									if (req_q.cmd != nand_pkg::READ_ID) begin
										state <= nand_pkg::IDLE;
									end else if (index == id_last) begin
										index <= '0;
										state <= nand_pkg::IDLE;
									end else begin
										index <= index + 1'b1;
										step <= nand_pkg::READ_DATA0;
									end
								end
								default: state <= nand_pkg::IDLE;
							endcase
						end
					endcase
				end
			endcase
		end
	end

	// --------------------
	// Request, result and ID buffer
	// --------------------
	always_ff @(posedge clk) begin
		if ((state == nand_pkg::IDLE) && activate) begin
			req_q <= req;
		end
		if (state == nand_pkg::EXEC) begin
			case (req_q.cmd)
				nand_pkg::GET_STATUS: data_out <= status;
				nand_pkg::GET_ID_BYTE: data_out <= (index < id_len) ? id_buf[index] : '0;
				nand_pkg::READ_STATUS, nand_pkg::BYPASS_DATA_RD: begin
					if (step == nand_pkg::READ_DATA1) begin
						data_out <= rd_data;
					end
				end
				nand_pkg::READ_ID: begin
					if (step == nand_pkg::READ_DATA1) begin
						id_buf[index] <= rd_data;
					end
				end
				default: ;
			endcase
		end
	end

endmodule

// File: source/nand_pin_driver.sv
`timescale 1ns/1ps
`include "nand_consts.svh"

module nand_pin_driver (
	input logic clk,
	input logic nreset,
	input nand_pkg::unit_pins_t cmd_pins,
	input nand_pkg::unit_pins_t addr_pins,
	input nand_pkg::unit_pins_t wr_pins,
	input nand_pkg::unit_pins_t rd_pins,
	input logic ce_n,
	input logic wp_n,
	output nand_pkg::nand_ctrl_t nand_ctrl,
	inout wire [`NAND_DATA_W-1:0] nand_data,
	input logic nand_rnb,
	output logic rnb,
	output logic [`NAND_DATA_W-1:0] bus_in
);

	nand_pkg::nand_ctrl_t ctrl_d;
	logic drive_d;
	logic drive_q;
	logic [`NAND_DATA_W-1:0] dout_d;
	logic [`NAND_DATA_W-1:0] dout_q;
	logic rnb_meta;

	// --------------------
	// Merge unit requests
	// --------------------
	always_comb begin
		ctrl_d.cle = cmd_pins.latch;
		ctrl_d.ale = addr_pins.latch;
		ctrl_d.we_n = cmd_pins.we_n & addr_pins.we_n & wr_pins.we_n & rd_pins.we_n;
		ctrl_d.re_n = cmd_pins.re_n & addr_pins.re_n & wr_pins.re_n & rd_pins.re_n;
		ctrl_d.ce_n = ce_n;
		ctrl_d.wp_n = wp_n;
		drive_d = cmd_pins.drive | addr_pins.drive | wr_pins.drive;
		// Command first, then address, then data write
		if (cmd_pins.drive) begin
			dout_d = cmd_pins.dout;
		end else if (addr_pins.drive) begin
			dout_d = addr_pins.dout;
		end else begin
			dout_d = wr_pins.dout;
		end
	end

	// --------------------
	// Pin registers
	// --------------------
	always_ff @(posedge clk) begin
		if (!nreset) begin
			nand_ctrl <= '{cle: 1'b0, ale: 1'b0, we_n: 1'b1, re_n: 1'b1,
				ce_n: 1'b1, wp_n: 1'b0};
			drive_q <= 1'b0;
			rnb_meta <= 1'b1;
			rnb <= 1'b1;
		end else begin
			nand_ctrl <= ctrl_d;
			drive_q <= drive_d;
			// Two-flop synchronizer for R/B#
			rnb_meta <= nand_rnb;
			rnb <= rnb_meta;
		end
	end

	always_ff @(posedge clk) begin
		dout_q <= dout_d;
		bus_in <= nand_data;
	end

	// Bus released when no unit writes
	assign nand_data = drive_q ? dout_q : 'z;

endmodule

// File: source/nand_io_unit.sv
`timescale 1ns/1ps
`include "nand_consts.svh"

module nand_io_unit #(
	// Set for the RE# unit, clear for the WE# unit
	parameter bit is_read = 1'b0
) (
	input logic clk,
	input logic nreset,
	input logic activate,
	input logic [`NAND_DATA_W-1:0] data,
	output logic busy,
	output nand_pkg::unit_pins_t pins,
	input logic [`NAND_DATA_W-1:0] bus_in,
	output logic [`NAND_DATA_W-1:0] rd_data
);

	localparam int low_cycles = is_read ? `T_RP : `T_WP;
	localparam int high_cycles = is_read ? `T_REH : `T_WH;
	localparam int cycles = low_cycles + high_cycles;
	localparam int cnt_w = $clog2(cycles);
	localparam logic [cnt_w-1:0] last_phase = cnt_w'(cycles - 1);
	localparam logic [cnt_w-1:0] low_end = cnt_w'(low_cycles);
	// bus_in trails the unit RE# by the pin register and the sampling register,
	// so the last low pin cycle shows up here one phase after the low phase
	localparam logic [cnt_w-1:0] capture_phase = cnt_w'(low_cycles + 1);

	logic [cnt_w-1:0] phase;
	logic [`NAND_DATA_W-1:0] data_q;
	logic strobe_n;

	// Phase counter
	always_ff @(posedge clk) begin
		if (!nreset) begin
			busy <= 1'b0;
			phase <= '0;
		end else if (!busy) begin
			if (activate) begin
				busy <= 1'b1;
				phase <= '0;
			end
		end else if (phase == last_phase) begin
			busy <= 1'b0;
		end else begin
			phase <= phase + 1'b1;
		end
	end

	// Write byte held for the cycle, read byte captured late in the cycle
	always_ff @(posedge clk) begin
		if (activate && !busy) begin
			data_q <= data;
		end
		if (is_read && busy && (phase == capture_phase)) begin
			rd_data <= bus_in;
		end
	end

	assign strobe_n = !(busy && (phase < low_end));

	// Strobe goes to RE# or WE#, only the writer owns the bus
	always_comb begin
		pins.latch = 1'b0;
		pins.we_n = is_read ? 1'b1 : strobe_n;
		pins.re_n = is_read ? strobe_n : 1'b1;
		pins.drive = !is_read && busy;
		pins.dout = data_q;
	end

endmodule

// File: source/nand_latch_unit.sv
`timescale 1ns/1ps
`include "nand_consts.svh"

module nand_latch_unit #(
	// Set for the ALE unit, clear for the CLE unit
	parameter bit is_address = 1'b0
) (
	input logic clk,
	input logic nreset,
	input logic activate,
	input logic [`NAND_DATA_W-1:0] data,
	output logic busy,
	output nand_pkg::unit_pins_t pins
);

	localparam int cycles = `T_WP + `T_WH;
	localparam int cnt_w = $clog2(cycles);
	localparam logic [cnt_w-1:0] last_phase = cnt_w'(cycles - 1);
	localparam logic [cnt_w-1:0] low_end = cnt_w'(`T_WP);

	logic [cnt_w-1:0] phase;
	logic [`NAND_DATA_W-1:0] data_q;

	// Phase counter, busy for exactly T_WP + T_WH cycles
	always_ff @(posedge clk) begin
		if (!nreset) begin
			busy <= 1'b0;
			phase <= '0;
		end else if (!busy) begin
			if (activate) begin
				busy <= 1'b1;
				phase <= '0;
			end
		end else if (phase == last_phase) begin
			busy <= 1'b0;
		end else begin
			phase <= phase + 1'b1;
		end
	end

	// Byte is held for the whole cycle
	always_ff @(posedge clk) begin
		if (activate && !busy) begin
			data_q <= data;
		end
	end

	// Latch line up for the whole cycle, WE# low in the first phase only
	always_comb begin
		pins.latch = busy;
		pins.we_n = !(busy && (phase < low_end));
		pins.re_n = 1'b1;
		pins.drive = busy;
		pins.dout = data_q;
	end

endmodule

// File: source/nand_pkg.sv
`include "nand_consts.svh"

package nand_pkg;

	// Host command codes
	typedef enum logic [5:0] {
		NAND_RESET     = 6'd0,
		GET_STATUS     = 6'd1,
		CHIP_ENABLE    = 6'd2,
		CHIP_DISABLE   = 6'd3,
		WRITE_PROTECT  = 6'd4,
		WRITE_ENABLE   = 6'd5,
		RESET_INDEX    = 6'd6,
		GET_ID_BYTE    = 6'd7,
		READ_STATUS    = 6'd8,
		READ_ID        = 6'd9,
		BYPASS_COMMAND = 6'd10,
		BYPASS_ADDRESS = 6'd11,
		BYPASS_DATA_WR = 6'd12,
		BYPASS_DATA_RD = 6'd13
	} host_cmd_e;

	// One host request, opcode plus optional byte
	typedef struct packed {
		host_cmd_e cmd;
		logic [`HOST_DATA_W-1:0] data;
	} host_req_t;

	// Main FSM
	typedef enum logic [1:0] {
		IDLE,
		EXEC,
		WAIT,
		DELAY
	} ctrl_state_e;

	// Position inside one NAND operation
	typedef enum logic [2:0] {
		BEGIN,
		SUBMIT_COMMAND,
		SUBMIT_ADDRESS,
		READ_DATA0,
		READ_DATA1,
		WRITE_DATA0,
		FINISH
	} step_e;

	// Controller status register
	typedef struct packed {
		logic [2:0] reserved;
		logic out_of_range;
		logic write_protected;
		logic chip_enabled;
		logic [1:0] zero;
	} status_t;

	// Pin requests of one latch or IO unit
	typedef struct packed {
		logic latch;
		logic we_n;
		logic re_n;
		logic drive;
		logic [`NAND_DATA_W-1:0] dout;
	} unit_pins_t;

	// NAND control pins
	typedef struct packed {
		logic cle;
		logic ale;
		logic we_n;
		logic re_n;
		logic ce_n;
		logic wp_n;
	} nand_ctrl_t;

endpackage

// File: source/nand_consts.svh
`ifndef NAND_CONSTS_SVH
`define NAND_CONSTS_SVH

// --------------------
// Bus widths
// --------------------

// NAND data bus, x8 parts only
`define NAND_DATA_W 8
// Host side data byte
`define HOST_DATA_W 8

// Bytes returned by READ ID
`define NAND_ID_LEN 5

// --------------------
// NAND opcode bytes
// --------------------
`define OP_RESET 8'hff
`define OP_READ_ID 8'h90
`define OP_READ_STATUS 8'h70

// --------------------
// Timing in clock cycles
// --------------------

// WE# low and high phases
`define T_WP 2
`define T_WH 2

// RE# low and high phases
`define T_RP 2
`define T_REH 2

// Command to R/B# sample point
`define T_WB 4

// Command to first data read
`define T_WHR 6

// Delay counter width
`define DELAY_W 8

// Status after reset, chip disabled and write protected
`define STATUS_RESET 8'h08

`endif
